// ==== verilog/cpuPkg.sv ====
package cpuPkg;

	localparam int wordSize = 16;
	localparam int regAddrBits = 2;

	localparam logic [3:0] opBne = 4'd0;
	localparam logic [3:0] opBeq = 4'd1;
	localparam logic [3:0] opAdi = 4'd4;
	localparam logic [3:0] opOri = 4'd5;
	localparam logic [3:0] opLhi = 4'd6;
	localparam logic [3:0] opAlu = 4'd15;

	localparam logic [5:0] fnAdd = 6'd0;
	localparam logic [5:0] fnSub = 6'd1;
	localparam logic [5:0] fnAnd = 6'd2;
	localparam logic [5:0] fnOrr = 6'd3;
	localparam logic [5:0] fnNot = 6'd4;
	localparam logic [5:0] fnTcp = 6'd5;
	localparam logic [5:0] fnShl = 6'd6;
	localparam logic [5:0] fnShr = 6'd7;
	localparam logic [5:0] fnWwd = 6'd28;
	localparam logic [5:0] fnHlt = 6'd29;

	// encoded in the same order as the R-type funcs 0 to 7
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOrr,
		aluNot,
		aluTcp,
		aluShl,
		aluShr
	} aluOpT;

	typedef enum logic [1:0] {
		immSign,
		immZero,
		immHigh
	} immKindT;

	typedef struct packed {
		logic regWrite;
		logic aluSrcImm; // operand b is the immediate, not rt
		immKindT immKind;
		aluOpT aluOp;
		logic destIsRd; // otherwise the result goes to rt
		logic isBranch;
		logic branchOnEq;
		logic isWwd;
		logic isHalt;
		logic [regAddrBits-1:0] rs;
		logic [regAddrBits-1:0] rt;
		logic [regAddrBits-1:0] rd;
		logic [7:0] imm;
		logic [wordSize-1:0] pc;
	} ctrlT;

endpackage

// ==== verilog/instrLink.sv ====
`timescale 1ns/1ps

interface instrLink;

	logic valid; // instr and pc are held while this is high
	logic [cpuPkg::wordSize-1:0] instr;
	logic [cpuPkg::wordSize-1:0] pc;
	logic take;
	logic [cpuPkg::wordSize-1:0] nextPc;
	logic pcLoad; // pulses once when an instruction retires

	modport fetch (
		output valid, instr, pc,
		input take, nextPc, pcLoad
	);

	modport decode (
		input valid, instr, pc,
		output take
	);

	modport exec (
		output nextPc, pcLoad
	);

endinterface

// ==== verilog/instrFetch.sv ====
`timescale 1ns/1ps

module instrFetch (
	input logic clk,
	input logic rstN,
	output logic instrReq,
	output logic [cpuPkg::wordSize-1:0] instrAddr,
	input logic instrAck,
	input logic [cpuPkg::wordSize-1:0] instrData,
	instrLink.fetch link
);

	typedef enum logic [1:0] {
		stReq,
		stAckLow,
		stPresent
	} fetchStateT;

	fetchStateT state;
	logic [cpuPkg::wordSize-1:0] pc;
	logic [cpuPkg::wordSize-1:0] instrReg;

	assign instrAddr = pc;
	assign link.pc = pc;
	assign link.instr = instrReg;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stReq; // the first request goes out one cycle after reset
			instrReq <= 1'b0;
			pc <= '0;
			link.valid <= 1'b0;
		end else begin
			case (state)
				stReq: begin
					if (instrReq && instrAck) begin
						instrReg <= instrData;
						instrReq <= 1'b0;
						state <= stAckLow;
					end else begin
						instrReq <= 1'b1;
					end
				end
				stAckLow: begin
					if (!instrAck) begin
						link.valid <= 1'b1;
						state <= stPresent;
					end
				end
				stPresent: begin
					if (link.take)
						link.valid <= 1'b0;
					if (link.pcLoad) begin // next fetch waits for the retire
						pc <= link.nextPc;
						instrReq <= 1'b1;
						state <= stReq;
					end
				end
				default: state <= stReq;
			endcase
		end
	end

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic rstN,
	instrLink.decode link,
	output cpuPkg::ctrlT ctrl,
	output logic ctrlValid
);

	logic [3:0] opcode;
	logic [5:0] func;
	cpuPkg::ctrlT dec;

	assign opcode = link.instr[15:12];
	assign func = link.instr[5:0];

	always_comb begin
		dec = '0; // unknown codes fall through to a bundle that does nothing
		dec.rs = link.instr[11:10];
		dec.rt = link.instr[9:8];
		dec.rd = link.instr[7:6];
		dec.imm = link.instr[7:0];
		dec.pc = link.pc;
		case (opcode)
			cpuPkg::opAlu: begin
				if (func <= cpuPkg::fnShr) begin
					dec.regWrite = 1'b1;
					dec.destIsRd = 1'b1;
					dec.aluOp = cpuPkg::aluOpT'(func[2:0]);
				end else if (func == cpuPkg::fnWwd) begin
					dec.isWwd = 1'b1;
				end else if (func == cpuPkg::fnHlt) begin
					dec.isHalt = 1'b1;
				end
			end
			cpuPkg::opAdi: begin
				dec.regWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.immKind = cpuPkg::immSign;
				dec.aluOp = cpuPkg::aluAdd;
			end
			cpuPkg::opOri: begin
				dec.regWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.immKind = cpuPkg::immZero;
				dec.aluOp = cpuPkg::aluOrr;
			end
			cpuPkg::opLhi: begin
				dec.regWrite = 1'b1;
				dec.aluSrcImm = 1'b1;
				dec.immKind = cpuPkg::immHigh; // execute zeroes operand a for this kind
				dec.aluOp = cpuPkg::aluOrr;
			end
			cpuPkg::opBne, cpuPkg::opBeq: begin
				dec.isBranch = 1'b1;
				dec.immKind = cpuPkg::immSign;
				dec.branchOnEq = (opcode == cpuPkg::opBeq);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrl <= '0;
			ctrlValid <= 1'b0;
			link.take <= 1'b0;
		end else begin
			ctrlValid <= 1'b0;
			link.take <= 1'b0;
			if (link.valid && !link.take) begin // valid is still high in the take cycle
				ctrl <= dec;
				ctrlValid <= 1'b1;
				link.take <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrlT ctrl,
	input logic ctrlValid,
	instrLink.exec link,
	output logic wwdStart,
	output logic [cpuPkg::wordSize-1:0] wwdValue,
	input logic wwdDone,
	output logic halted
);

	logic [cpuPkg::wordSize-1:0] regs [4];
	logic [cpuPkg::wordSize-1:0] rsVal;
	logic [cpuPkg::wordSize-1:0] rtVal;
	logic [cpuPkg::wordSize-1:0] immSext;
	logic [cpuPkg::wordSize-1:0] immOp;
	logic [cpuPkg::wordSize-1:0] opA;
	logic [cpuPkg::wordSize-1:0] opB;
	logic [cpuPkg::wordSize-1:0] aluResult;
	logic [cpuPkg::wordSize-1:0] pcPlus1;
	logic [cpuPkg::regAddrBits-1:0] destIdx;
	logic branchTaken;
	logic waitWwd;

	assign rsVal = regs[ctrl.rs];
	assign rtVal = regs[ctrl.rt];
	assign immSext = {{8{ctrl.imm[7]}}, ctrl.imm};
	assign destIdx = ctrl.destIsRd ? ctrl.rd : ctrl.rt;

	always_comb begin
		case (ctrl.immKind)
			cpuPkg::immZero: immOp = {8'h00, ctrl.imm};
			cpuPkg::immHigh: immOp = {ctrl.imm, 8'h00};
			default: immOp = immSext;
		endcase
	end

	// LHI is an OR of the shifted immediate into zero
	assign opA = (ctrl.aluSrcImm && ctrl.immKind == cpuPkg::immHigh) ? '0 : rsVal;
	assign opB = ctrl.aluSrcImm ? immOp : rtVal;

	always_comb begin
		case (ctrl.aluOp)
			cpuPkg::aluAdd: aluResult = opA + opB;
			cpuPkg::aluSub: aluResult = opA - opB;
			cpuPkg::aluAnd: aluResult = opA & opB;
			cpuPkg::aluOrr: aluResult = opA | opB;
			cpuPkg::aluNot: aluResult = ~opA;
			cpuPkg::aluTcp: aluResult = ~opA + 1'b1;
			cpuPkg::aluShl: aluResult = opA << 1;
			default: aluResult = opA >> 1; // logical shift
		endcase
	end

	assign pcPlus1 = ctrl.pc + 1'b1;
	assign branchTaken = ctrl.isBranch && ((rsVal == rtVal) == ctrl.branchOnEq);
	// ctrl is held from decode until the next fetch
	assign link.nextPc = branchTaken ? pcPlus1 + immSext : pcPlus1;
	assign wwdValue = rsVal;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
			halted <= 1'b0;
			waitWwd <= 1'b0;
			wwdStart <= 1'b0;
			link.pcLoad <= 1'b0;
		end else begin
			wwdStart <= 1'b0;
			link.pcLoad <= 1'b0;
			if (ctrlValid && !halted) begin
				if (ctrl.isHalt) begin
					halted <= 1'b1; // no pcLoad, so fetch stops here
				end else if (ctrl.isWwd) begin
					wwdStart <= 1'b1;
					waitWwd <= 1'b1;
				end else begin
					if (ctrl.regWrite)
						regs[destIdx] <= aluResult;
					link.pcLoad <= 1'b1;
				end
			end else if (waitWwd && wwdDone) begin
				waitWwd <= 1'b0;
				link.pcLoad <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/wwdPort.sv ====
`timescale 1ns/1ps

module wwdPort (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic [cpuPkg::wordSize-1:0] value,
	output logic outReq,
	output logic [cpuPkg::wordSize-1:0] outData,
	input logic outAck,
	output logic done
);

	typedef enum logic [1:0] {
		stIdle,
		stReq,
		stAckLow
	} sendStateT;

	sendStateT state;

	assign outReq = (state == stReq);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				stIdle: begin
					if (start) begin
						outData <= value; // held until the ack comes back
						state <= stReq;
					end
				end
				stReq: if (outAck) state <= stAckLow;
				stAckLow: begin
					if (!outAck) begin
						done <= 1'b1;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input logic clk,
	input logic rstN,
	output logic instrReq,
	output logic [cpuPkg::wordSize-1:0] instrAddr,
	input logic instrAck,
	input logic [cpuPkg::wordSize-1:0] instrData,
	output logic outReq,
	output logic [cpuPkg::wordSize-1:0] outData,
	input logic outAck,
	output logic halted
);

	cpuPkg::ctrlT ctrl;
	logic ctrlValid;
	logic wwdStart;
	logic [cpuPkg::wordSize-1:0] wwdValue;
	logic wwdDone;

	instrLink link ();

	instrFetch i_instrFetch (
		.clk(clk),
		.rstN(rstN),
		.instrReq(instrReq),
		.instrAddr(instrAddr),
		.instrAck(instrAck),
		.instrData(instrData),
		.link(link.fetch)
	);

	controlUnit i_controlUnit (
		.clk(clk),
		.rstN(rstN),
		.link(link.decode),
		.ctrl(ctrl),
		.ctrlValid(ctrlValid)
	);

	execUnit i_execUnit (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.ctrlValid(ctrlValid),
		.link(link.exec),
		.wwdStart(wwdStart),
		.wwdValue(wwdValue),
		.wwdDone(wwdDone),
		.halted(halted)
	);

	wwdPort i_wwdPort (
		.clk(clk),
		.rstN(rstN),
		.start(wwdStart),
		.value(wwdValue),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck),
		.done(wwdDone)
	);

endmodule

// ==== sim/cpuTop_sva.sv ====
`timescale 1ns/1ps

module cpuTopSva (
	input logic clk,
	input logic rstN,
	input logic instrReq,
	input logic [cpuPkg::wordSize-1:0] instrAddr,
	input logic instrAck,
	input logic outReq,
	input logic [cpuPkg::wordSize-1:0] outData,
	input logic outAck,
	input logic halted
);

	instrReqHeld: assert property (@(posedge clk) disable iff (!rstN)
		instrReq && !instrAck |=> instrReq && $stable(instrAddr))
		else $error("instrReq dropped or instrAddr moved before instrAck");

	outReqHeld: assert property (@(posedge clk) disable iff (!rstN)
		outReq && !outAck |=> outReq && $stable(outData))
		else $error("outReq dropped or outData moved before outAck");

	haltSticky: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted)
		else $error("halted fell without a reset");

endmodule

bind cpuTop cpuTopSva i_cpuTopSva (.*);

// ==== sim/cpuTopTb.sv ====
`timescale 1ns/1ps

module cpuTopTb;

	localparam int instrTotal = 70; // rounded up from the instructions the model runs in all programs
	localparam int outSlowDelay = 30;

	logic clk;
	logic rstN;
	logic instrReq;
	logic [cpuPkg::wordSize-1:0] instrAddr;
	logic instrAck;
	logic [cpuPkg::wordSize-1:0] instrData;
	logic outReq;
	logic [cpuPkg::wordSize-1:0] outData;
	logic outAck;
	logic halted;

	logic [cpuPkg::wordSize-1:0] prog [256];
	logic [cpuPkg::wordSize-1:0] gotFetch [$];
	logic [cpuPkg::wordSize-1:0] gotOut [$];
	logic [cpuPkg::wordSize-1:0] expFetch [$];
	logic [cpuPkg::wordSize-1:0] expOut [$];
	logic [15:0] inLfsr;
	logic [15:0] outLfsr;
	int inDelay;
	int outDelay;
	logic inWaiting;
	logic outWaiting;
	logic slowOut;
	int valueErrors;
	int otherErrors;

	cpuTop i_cpuTop (
		.clk(clk),
		.rstN(rstN),
		.instrReq(instrReq),
		.instrAddr(instrAddr),
		.instrAck(instrAck),
		.instrData(instrData),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#((instrTotal * 40 + 200) * 40);
		$display("Timeout: the programs did not all reach HLT in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// taps 16, 14, 13, 11 with the new bit shifted in at the bottom
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] encodeR(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd, input logic [5:0] fn);
		return {cpuPkg::opAlu, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] encodeI(input logic [3:0] op, input logic [1:0] rs,
			input logic [1:0] rt, input int imm);
		return {op, rs, rt, 8'(imm)};
	endfunction

	// the instruction source answers each request after 0 to 3 cycles
	always @(posedge clk) begin
		if (!rstN) begin
			instrAck <= 1'b0;
			inWaiting = 1'b0;
		end else if (instrAck) begin
			if (!instrReq)
				instrAck <= 1'b0;
		end else if (instrReq) begin
			if (!inWaiting) begin
				repeat (2) inLfsr = lfsrNext(inLfsr);
				inDelay = int'(inLfsr[1:0]);
				inWaiting = 1'b1;
			end
			if (inDelay == 0) begin
				instrAck <= 1'b1;
				instrData <= prog[instrAddr[7:0]];
				gotFetch.push_back(instrAddr);
				inWaiting = 1'b0;
			end else begin
				inDelay--;
			end
		end
	end

	always @(posedge clk) begin
		if (!rstN) begin
			outAck <= 1'b0;
			outWaiting = 1'b0;
		end else if (outAck) begin
			if (!outReq)
				outAck <= 1'b0;
		end else if (outReq) begin
			if (!outWaiting) begin
				if (slowOut) begin
					outDelay = outSlowDelay;
				end else begin
					repeat (2) outLfsr = lfsrNext(outLfsr);
					outDelay = int'(outLfsr[1:0]);
				end
				outWaiting = 1'b1;
			end
			if (outDelay == 0) begin
				outAck <= 1'b1;
				gotOut.push_back(outData);
				outWaiting = 1'b0;
			end else begin
				outDelay--;
			end
		end
	end

	// the core fetches nothing while a WWD handshake is still open
	always @(negedge clk) begin
		if (rstN && instrReq && (outReq || outAck)) begin
			otherErrors++;
			$display("Instruction request at %0t while the output handshake is open", $time);
		end
	end

	task automatic checkWord(input string name, input logic [cpuPkg::wordSize-1:0] expected,
			input logic [cpuPkg::wordSize-1:0] actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic clearProg();
		for (int i = 0; i < 256; i++)
			prog[i] = {4'h2, 4'h0, 8'(i)}; // opcode 2 does nothing
	endtask

	task automatic runModel();
		logic [cpuPkg::wordSize-1:0] r [4];
		logic [cpuPkg::wordSize-1:0] pc;
		logic [cpuPkg::wordSize-1:0] ins;
		logic [cpuPkg::wordSize-1:0] a;
		logic [cpuPkg::wordSize-1:0] b;
		logic [cpuPkg::wordSize-1:0] sext;
		logic stop;
		int steps;
		expFetch.delete();
		expOut.delete();
		for (int i = 0; i < 4; i++)
			r[i] = '0;
		pc = '0;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 500) begin
			expFetch.push_back(pc);
			ins = prog[pc[7:0]];
			a = r[ins[11:10]];
			b = r[ins[9:8]];
			sext = {{8{ins[7]}}, ins[7:0]};
			pc = pc + 16'd1;
			case (ins[15:12])
				cpuPkg::opBne: if (a != b) pc = pc + sext;
				cpuPkg::opBeq: if (a == b) pc = pc + sext;
				cpuPkg::opAdi: r[ins[9:8]] = a + sext;
				cpuPkg::opOri: r[ins[9:8]] = a | {8'h00, ins[7:0]};
				cpuPkg::opLhi: r[ins[9:8]] = {ins[7:0], 8'h00};
				cpuPkg::opAlu: begin
					case (ins[5:0])
						cpuPkg::fnAdd: r[ins[7:6]] = a + b;
						cpuPkg::fnSub: r[ins[7:6]] = a - b;
						cpuPkg::fnAnd: r[ins[7:6]] = a & b;
						cpuPkg::fnOrr: r[ins[7:6]] = a | b;
						cpuPkg::fnNot: r[ins[7:6]] = ~a;
						cpuPkg::fnTcp: r[ins[7:6]] = 16'd0 - a;
						cpuPkg::fnShl: r[ins[7:6]] = a << 1;
						cpuPkg::fnShr: r[ins[7:6]] = a >> 1;
						cpuPkg::fnWwd: expOut.push_back(a);
						cpuPkg::fnHlt: stop = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			steps++;
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		checkBit("instrReq", 1'b0, instrReq);
		checkBit("outReq", 1'b0, outReq);
		checkBit("halted", 1'b0, halted);
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic runProgram(input string name);
		int limit;
		int n;
		int fetchesAtHalt;
		logic lateReq;
		runModel();
		gotFetch.delete();
		gotOut.delete();
		applyReset();
		limit = expFetch.size() * 40 + 100;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			otherErrors++;
			$display("%s: halted did not rise within %0d cycles", name, limit);
		end
		fetchesAtHalt = gotFetch.size();
		lateReq = 1'b0;
		repeat (50) begin
			@(negedge clk);
			lateReq = lateReq | instrReq;
		end
		if (lateReq || gotFetch.size() != fetchesAtHalt) begin
			otherErrors++;
			$display("%s: the core requested an instruction after HLT", name);
		end
		if (gotFetch.size() != expFetch.size()) begin
			otherErrors++;
			$display("%s: %0d fetches seen, %0d expected", name, gotFetch.size(), expFetch.size());
		end
		for (int i = 0; i < gotFetch.size() && i < expFetch.size(); i++)
			checkWord("instrAddr", expFetch[i], gotFetch[i]);
		if (gotOut.size() != expOut.size()) begin
			otherErrors++;
			$display("%s: %0d outputs seen, %0d expected", name, gotOut.size(), expOut.size());
		end
		for (int i = 0; i < gotOut.size() && i < expOut.size(); i++)
			checkWord("outData", expOut[i], gotOut[i]);
	endtask

	task automatic testAluOps();
		clearProg();
		prog[0] = encodeI(cpuPkg::opLhi, 2'd0, 2'd1, 'h12);
		prog[1] = encodeI(cpuPkg::opOri, 2'd1, 2'd1, 'h34); // r1 = 1234
		prog[2] = encodeI(cpuPkg::opLhi, 2'd0, 2'd2, 'hF0);
		prog[3] = encodeI(cpuPkg::opOri, 2'd2, 2'd2, 'h0F); // r2 = f00f
		for (int f = 0; f < 8; f++) begin
			prog[4 + 2 * f] = encodeR(2'd1 + 2'(f / 6), 2'd2, 2'd3, 6'(f)); // shifts use r2
			prog[5 + 2 * f] = encodeR(2'd3, 2'd0, 2'd0, cpuPkg::fnWwd);
		end
		prog[20] = encodeR(2'd0, 2'd0, 2'd0, cpuPkg::fnHlt);
		runProgram("ALU ops");
	endtask

	task automatic testImmediates();
		clearProg();
		prog[0] = encodeI(cpuPkg::opAdi, 2'd0, 2'd1, -5);
		prog[1] = encodeR(2'd1, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[2] = encodeI(cpuPkg::opAdi, 2'd1, 2'd2, 100);
		prog[3] = encodeR(2'd2, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[4] = encodeI(cpuPkg::opOri, 2'd2, 2'd3, 'hA0);
		prog[5] = encodeR(2'd3, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[6] = encodeI(cpuPkg::opLhi, 2'd0, 2'd0, 'hC3);
		prog[7] = encodeR(2'd0, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[8] = encodeI(cpuPkg::opAdi, 2'd0, 2'd0, 127);
		prog[9] = encodeR(2'd0, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[10] = encodeR(2'd0, 2'd0, 2'd0, cpuPkg::fnHlt);
		runProgram("immediates");
	endtask

	task automatic testBranches();
		clearProg();
		prog[0] = encodeI(cpuPkg::opAdi, 2'd0, 2'd3, 1);
		prog[1] = encodeI(cpuPkg::opAdi, 2'd0, 2'd1, 2);
		prog[2] = encodeI(cpuPkg::opBeq, 2'd0, 2'd0, 1); // taken forward over 3
		prog[3] = encodeI(cpuPkg::opAdi, 2'd0, 2'd1, 7);
		prog[4] = encodeI(cpuPkg::opBne, 2'd0, 2'd0, 4); // never taken
		prog[5] = encodeI(cpuPkg::opAdi, 2'd1, 2'd1, -1);
		prog[6] = encodeR(2'd1, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[7] = encodeI(cpuPkg::opBne, 2'd1, 2'd0, -3); // back to 5 until r1 is zero
		prog[8] = encodeI(cpuPkg::opAdi, 2'd2, 2'd2, 1);
		prog[9] = encodeR(2'd2, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[10] = encodeI(cpuPkg::opBeq, 2'd2, 2'd3, -11); // back to 0 on the first pass only
		prog[11] = encodeR(2'd0, 2'd0, 2'd0, cpuPkg::fnHlt);
		runProgram("branches");
	endtask

	task automatic testBackPressure();
		clearProg();
		prog[0] = encodeI(cpuPkg::opAdi, 2'd0, 2'd1, 'h55);
		prog[1] = encodeR(2'd1, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[2] = encodeI(cpuPkg::opAdi, 2'd1, 2'd1, 1);
		prog[3] = encodeR(2'd1, 2'd0, 2'd0, cpuPkg::fnWwd);
		prog[4] = encodeR(2'd0, 2'd0, 2'd0, cpuPkg::fnHlt);
		slowOut = 1'b1;
		runProgram("back-pressure and halt");
		slowOut = 1'b0;
	endtask

	initial begin
		rstN <= 1'b0;
		instrAck <= 1'b0;
		instrData <= '0;
		outAck <= 1'b0;
		slowOut = 1'b0;
		inLfsr = 16'd9935;
		outLfsr = 16'd9935;
		inWaiting = 1'b0;
		outWaiting = 1'b0;
		valueErrors = 0;
		otherErrors = 0;
		testAluOps();
		testImmediates();
		testBranches();
		testBackPressure();
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== list.f ====
verilog/cpuPkg.sv
verilog/instrLink.sv
verilog/instrFetch.sv
verilog/controlUnit.sv
verilog/execUnit.sv
verilog/wwdPort.sv
verilog/cpuTop.sv
sim/cpuTop_sva.sv
sim/cpuTopTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpuTopTb -f list.f
./obj_dir/VcpuTopTb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0
